// File: common/uart_line_pkg.sv
package uart_line_pkg;

  // serial frame layout: start, data lsb first, parity, stop
  localparam int DATA_BITS  = 8;
  localparam int FRAME_BITS = 11;

  typedef logic [DATA_BITS-1:0] byte_t;

  // parity bit that leaves an odd count of ones over data plus parity
  function automatic logic odd_parity(byte_t data);
    return ~^data;
  endfunction

  // full frame, bit 0 goes on the line first
  function automatic logic [FRAME_BITS-1:0] make_frame(byte_t data);
    logic [FRAME_BITS-1:0] frame;
    frame = {1'b1, odd_parity(data), data, 1'b0};
    return frame;
  endfunction

endpackage

// File: common/uart_cmd_pkg.sv
package uart_cmd_pkg;

  // command word: [15] write flag, [14:8] address, [7:0] write data
  localparam int CMD_WIDTH = 16;
  localparam int RW_BIT    = 15;

  typedef logic [CMD_WIDTH-1:0] cmd_t;

  // sequencer states
  typedef enum logic [2:0] {
    IDLE     = 3'd0,
    SEND_HI  = 3'd1,
    SEND_LO  = 3'd2,
    WAIT_RSP = 3'd3,
    DONE     = 3'd4
  } seq_state_e;

endpackage

// File: common/tx_lane_if.sv
`timescale 1ns/1ps

interface tx_lane_if;

  logic                 start;
  uart_line_pkg::byte_t tx_byte;
  logic                 busy;
  logic                 done;

  modport seq (
    output start,
    output tx_byte,
    input  busy,
    input  done
  );

  modport shifter (
    input  start,
    input  tx_byte,
    output busy,
    output done
  );

endinterface

// File: rtl/baud_timer.sv
`timescale 1ns/1ps

module baud_timer #(
  parameter int CLKS_PER_BIT = 434
) (
  input  logic clk,
  input  logic rst_n,
  input  logic run,
  input  logic half_first,
  output logic tick
);

  localparam int CW = $clog2(CLKS_PER_BIT);
  localparam logic [CW-1:0] FULL_LAST = CW'(CLKS_PER_BIT - 1);
  localparam logic [CW-1:0] HALF_LAST = CW'(CLKS_PER_BIT / 2 - 1);

  logic [CW-1:0] cnt;
  logic          run_q;
  // current period is the shortened first one
  logic          short_q;

  assign tick = run && (cnt == (short_q ? HALF_LAST : FULL_LAST));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt     <= '0;
      run_q   <= 1'b0;
      short_q <= 1'b0;
    end else begin
      run_q <= run;
      if (!run) begin
        cnt     <= '0;
        short_q <= 1'b0;
      end else if (tick) begin
        cnt     <= '0;
        short_q <= 1'b0;
      end else begin
        cnt <= cnt + 1'b1;
        // half_first only matters on the cycle run rises
        if (!run_q) begin
          short_q <= half_first;
        end
      end
    end
  end

endmodule

// File: uart_core/uart_tx_shift.sv
`timescale 1ns/1ps

module uart_tx_shift (
  input  logic           clk,
  input  logic           rst_n,
  tx_lane_if.shifter     lane,
  input  logic           tick,
  output logic           run,
  output logic           tx
);

  localparam int FB = uart_line_pkg::FRAME_BITS;
  localparam logic [3:0] LAST_BIT = 4'(FB - 1);

  // line side of the frame is bit 0, idles at all ones
  logic [FB-1:0] frame_q;
  logic [3:0]    bit_cnt;
  logic          busy_q;
  logic          done_q;

  assign tx        = frame_q[0];
  assign run       = busy_q;
  assign lane.busy = busy_q;
  assign lane.done = done_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      frame_q <= '1;
      bit_cnt <= '0;
      busy_q  <= 1'b0;
      done_q  <= 1'b0;
    end else begin
      done_q <= 1'b0;
      if (lane.start && !busy_q) begin
        frame_q <= uart_line_pkg::make_frame(lane.tx_byte);
        bit_cnt <= '0;
        busy_q  <= 1'b1;
      end else if (busy_q && tick) begin
        frame_q <= {1'b1, frame_q[FB-1:1]};
        // last tick closes the stop bit
        if (bit_cnt == LAST_BIT) begin
          bit_cnt <= '0;
          busy_q  <= 1'b0;
          done_q  <= 1'b1;
        end else begin
          bit_cnt <= bit_cnt + 1'b1;
        end
      end
    end
  end

endmodule

// File: uart_core/uart_rx_shift.sv
`timescale 1ns/1ps

module uart_rx_shift (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 rx,
  input  logic                 arm,
  input  logic                 tick,
  output logic                 run,
  output logic                 half_first,
  output uart_line_pkg::byte_t rx_byte,
  output logic                 rx_good,
  output logic                 rx_bad
);

  localparam int DB = uart_line_pkg::DATA_BITS;
  localparam logic [3:0] PAR_BIT  = 4'(DB + 1);
  localparam logic [3:0] STOP_BIT = 4'(uart_line_pkg::FRAME_BITS - 1);

  logic [2:0]           sync_q;
  logic                 rx_s;
  logic                 fall;
  logic                 busy_q;
  logic [3:0]           bit_cnt;
  uart_line_pkg::byte_t data_q;
  logic                 par_q;
  logic                 start_err_q;

  assign rx_s = sync_q[1];
  assign fall = sync_q[2] & ~sync_q[1];

  assign run        = busy_q;
  // start bit phase gets the half period so samples sit mid-bit
  assign half_first = busy_q && (bit_cnt == '0);
  assign rx_byte    = data_q;

  // three-flop synchronizer, preset high like the idle line
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sync_q <= 3'b111;
    end else begin
      sync_q <= {sync_q[1:0], rx};
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy_q      <= 1'b0;
      bit_cnt     <= '0;
      start_err_q <= 1'b0;
      rx_good     <= 1'b0;
      rx_bad      <= 1'b0;
    end else begin
      rx_good <= 1'b0;
      rx_bad  <= 1'b0;
      if (!busy_q) begin
        if (arm && fall) begin
          busy_q      <= 1'b1;
          bit_cnt     <= '0;
          start_err_q <= 1'b0;
        end
      end else if (tick) begin
        if (bit_cnt == STOP_BIT) begin
          busy_q  <= 1'b0;
          bit_cnt <= '0;
          if (start_err_q || !rx_s || (par_q != uart_line_pkg::odd_parity(data_q))) begin
            rx_bad <= 1'b1;
          end else begin
            rx_good <= 1'b1;
          end
        end else begin
          bit_cnt <= bit_cnt + 1'b1;
          // glitch, start bit no longer low at mid-bit
          if (bit_cnt == '0 && rx_s) begin
            start_err_q <= 1'b1;
          end
        end
      end
    end
  end

  // data and parity capture
  always_ff @(posedge clk) begin
    if (busy_q && tick) begin
      if (bit_cnt != '0 && bit_cnt < PAR_BIT) begin
        data_q <= {rx_s, data_q[DB-1:1]};
      end
      if (bit_cnt == PAR_BIT) begin
        par_q <= rx_s;
      end
    end
  end

endmodule

// File: rtl/cmd_sequencer.sv
`timescale 1ns/1ps

module cmd_sequencer (
  input  logic               clk,
  input  logic               rst_n,
  input  uart_cmd_pkg::cmd_t cmd_in,
  input  logic               cmd_vld,
  output logic               cmd_rdy,
  tx_lane_if.seq             lane,
  output logic               rx_arm,
  input  logic               rx_good,
  input  logic               rx_bad
);

  localparam int DB = uart_line_pkg::DATA_BITS;
  localparam int CW = uart_cmd_pkg::CMD_WIDTH;

  uart_cmd_pkg::seq_state_e state;
  uart_cmd_pkg::cmd_t       cmd_q;
  uart_line_pkg::byte_t     byte_q;
  logic                     start_q;
  logic                     is_write;

  assign is_write = cmd_q[uart_cmd_pkg::RW_BIT];

  assign cmd_rdy      = (state == uart_cmd_pkg::IDLE);
  assign rx_arm       = (state == uart_cmd_pkg::WAIT_RSP);
  assign lane.start   = start_q;
  assign lane.tx_byte = byte_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= uart_cmd_pkg::IDLE;
      start_q <= 1'b0;
    end else begin
      start_q <= 1'b0;
      case (state)
        uart_cmd_pkg::IDLE: begin
          if (cmd_vld) begin
            state <= uart_cmd_pkg::SEND_HI;
          end
        end
        uart_cmd_pkg::SEND_HI: begin
          // done wins over a new start, both see busy low
          if (lane.done) begin
            if (is_write) begin
              start_q <= 1'b1;
              state   <= uart_cmd_pkg::SEND_LO;
            end else begin
              state <= uart_cmd_pkg::WAIT_RSP;
            end
          end else if (!lane.busy && !start_q) begin
            start_q <= 1'b1;
          end
        end
        uart_cmd_pkg::SEND_LO: begin
          // low frame launched
          state <= uart_cmd_pkg::DONE;
        end
        uart_cmd_pkg::DONE: begin
          if (lane.done) begin
            state <= uart_cmd_pkg::IDLE;
          end
        end
        uart_cmd_pkg::WAIT_RSP: begin
          if (rx_good || rx_bad) begin
            state <= uart_cmd_pkg::IDLE;
          end
        end
        default: begin
          state <= uart_cmd_pkg::IDLE;
        end
      endcase
    end
  end

  // command and outgoing byte
  always_ff @(posedge clk) begin
    if (cmd_rdy && cmd_vld) begin
      cmd_q <= cmd_in;
    end
    if (state == uart_cmd_pkg::SEND_HI) begin
      if (lane.done) begin
        byte_q <= cmd_q[DB-1:0];
      end else begin
        byte_q <= cmd_q[CW-1 -: DB];
      end
    end
  end

endmodule

// File: rtl/uart_cmd_bridge.sv
`timescale 1ns/1ps

module uart_cmd_bridge #(
  parameter int CLKS_PER_BIT = 434
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  uart_cmd_pkg::cmd_t   cmd_in,
  input  logic                 cmd_vld,
  output logic                 cmd_rdy,
  input  logic                 rx,
  output logic                 tx,
  output uart_line_pkg::byte_t read_data,
  output logic                 read_rdy,
  output logic                 parity_err
);

  logic tx_run;
  logic tx_tick;
  logic rx_run;
  logic rx_half;
  logic rx_tick;
  logic rx_arm;

  tx_lane_if lane ();

  cmd_sequencer cmd_sequencer_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .cmd_in  (cmd_in),
    .cmd_vld (cmd_vld),
    .cmd_rdy (cmd_rdy),
    .lane    (lane.seq),
    .rx_arm  (rx_arm),
    .rx_good (read_rdy),
    .rx_bad  (parity_err)
  );

  uart_tx_shift uart_tx_shift_i (
    .clk   (clk),
    .rst_n (rst_n),
    .lane  (lane.shifter),
    .tick  (tx_tick),
    .run   (tx_run),
    .tx    (tx)
  );

  baud_timer #(.CLKS_PER_BIT(CLKS_PER_BIT)) tx_timer_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .run        (tx_run),
    .half_first (1'b0),
    .tick       (tx_tick)
  );

  uart_rx_shift uart_rx_shift_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .rx         (rx),
    .arm        (rx_arm),
    .tick       (rx_tick),
    .run        (rx_run),
    .half_first (rx_half),
    .rx_byte    (read_data),
    .rx_good    (read_rdy),
    .rx_bad     (parity_err)
  );

  baud_timer #(.CLKS_PER_BIT(CLKS_PER_BIT)) rx_timer_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .run        (rx_run),
    .half_first (rx_half),
    .tick       (rx_tick)
  );

endmodule

// File: dv/tb_uart_cmd_bridge.sv
`timescale 1ns/1ps

module tb_uart_cmd_bridge;

  localparam int CPB = 16;
  localparam int FB = uart_line_pkg::FRAME_BITS;
  localparam int DB = uart_line_pkg::DATA_BITS;
  localparam int TEST_CYCLES = 40 * FB * CPB;

  logic                 clk;
  logic                 rst_n;
  uart_cmd_pkg::cmd_t   cmd_in;
  logic                 cmd_vld;
  logic                 cmd_rdy;
  logic                 rx;
  logic                 tx;
  uart_line_pkg::byte_t read_data;
  logic                 read_rdy;
  logic                 parity_err;

  integer               seed;
  int                   errors;
  int                   rdy_cnt;
  int                   err_cnt;
  uart_line_pkg::byte_t last_read;
  uart_line_pkg::byte_t tx_q[$];

  // trace columns
  uart_cmd_pkg::cmd_t   t_cmd[$];
  uart_line_pkg::byte_t t_rsp[$];
  int                   t_err[$];
  int                   t_gap[$];
  uart_line_pkg::byte_t t_exp[$];

  uart_cmd_bridge #(.CLKS_PER_BIT(CPB)) uart_cmd_bridge_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .cmd_in     (cmd_in),
    .cmd_vld    (cmd_vld),
    .cmd_rdy    (cmd_rdy),
    .rx         (rx),
    .tx         (tx),
    .read_data  (read_data),
    .read_rdy   (read_rdy),
    .parity_err (parity_err)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic report_mismatch(input string msg);
    $display("MISMATCH %0t %s", $time, msg);
    errors++;
  endtask

  // response pulses as the host sees them
  always @(negedge clk) begin
    if (rst_n && read_rdy) begin
      rdy_cnt++;
      last_read = read_data;
    end
    if (rst_n && parity_err) err_cnt++;
  end

  // tx line decoder sampling each bit mid-period
  initial begin : tx_monitor
    uart_line_pkg::byte_t data;
    logic par;
    @(posedge rst_n);
    forever begin
      @(negedge tx);
      repeat (CPB / 2) @(negedge clk);
      if (tx !== 1'b0) report_mismatch("tx start bit not low at mid-bit");
      for (int i = 0; i < DB; i++) begin
        repeat (CPB) @(negedge clk);
        data[i] = tx;
      end
      repeat (CPB) @(negedge clk);
      par = tx;
      if ((^data ^ par) !== 1'b1) report_mismatch($sformatf("tx parity wrong for %h", data));
      repeat (CPB) @(negedge clk);
      if (tx !== 1'b1) report_mismatch("tx stop bit not high");
      tx_q.push_back(data);
    end
  end

  task automatic issue_cmd(input uart_cmd_pkg::cmd_t c);
    @(negedge clk);
    cmd_in  = c;
    cmd_vld = 1'b1;
    @(negedge clk);
    while (cmd_rdy) @(negedge clk);
    // valid stays up with other data while the bridge is busy
    cmd_in = ~c;
    repeat (3) @(negedge clk);
    cmd_vld = 1'b0;
    cmd_in  = '0;
  endtask

  task automatic drive_rx_frame(input uart_line_pkg::byte_t b, input int err, input int gap);
    logic [FB-1:0] f;
    int extra;
    extra = $random(seed) & 3;
    f = {1'b1, uart_line_pkg::odd_parity(b), b, 1'b0};
    if (err == 1) f[FB-2] = ~f[FB-2];
    if (err == 2) f[FB-1] = 1'b0;
    repeat ((gap + extra) * CPB) @(negedge clk);
    for (int i = 0; i < FB; i++) begin
      rx = f[i];
      repeat (CPB) @(negedge clk);
    end
    rx = 1'b1;
  endtask

  task automatic run_test(input int n);
    uart_cmd_pkg::cmd_t c;
    logic wr;
    int rdy0;
    int err0;
    int exp_good;
    int exp_bad;
    c = t_cmd[n];
    wr = c[uart_cmd_pkg::RW_BIT];
    rdy0 = rdy_cnt;
    err0 = err_cnt;
    exp_good = (!wr && t_err[n] == 0) ? 1 : 0;
    exp_bad = (!wr && t_err[n] != 0) ? 1 : 0;
    tx_q.delete();
    issue_cmd(c);
    if (wr) begin
      // stray rx traffic while the receiver is not armed
      drive_rx_frame(t_rsp[n], t_err[n], t_gap[n]);
    end else begin
      while (tx_q.size() == 0) @(negedge clk);
      repeat (CPB) @(negedge clk);
      drive_rx_frame(t_rsp[n], t_err[n], t_gap[n]);
    end
    while (!cmd_rdy) @(negedge clk);
    if (tx_q.size() != (wr ? 2 : 1)) begin
      report_mismatch($sformatf("cmd %h gave %0d tx frames", c, tx_q.size()));
    end else begin
      if (tx_q[0] != c[15:8]) begin
        report_mismatch($sformatf("high byte %h, want %h", tx_q[0], c[15:8]));
      end
      if (wr && tx_q[1] != c[7:0]) begin
        report_mismatch($sformatf("low byte %h, want %h", tx_q[1], c[7:0]));
      end
    end
    if (rdy_cnt - rdy0 != exp_good) begin
      report_mismatch($sformatf("%0d read_rdy pulses, want %0d", rdy_cnt - rdy0, exp_good));
    end
    if (err_cnt - err0 != exp_bad) begin
      report_mismatch($sformatf("%0d parity_err pulses, want %0d", err_cnt - err0, exp_bad));
    end
    if (exp_good == 1 && last_read != t_exp[n]) begin
      report_mismatch($sformatf("read_data %h, want %h", last_read, t_exp[n]));
    end
  endtask

  task automatic watch_timeout(input int cycles);
    repeat (cycles) @(posedge clk);
    $display("timeout: run did not finish within %0d cycles, sequencer state %0d",
             cycles, uart_cmd_bridge_i.cmd_sequencer_i.state);
    $display("Regression failed");
    $finish;
  endtask

  initial begin : main
    int fd;
    string line;
    uart_cmd_pkg::cmd_t c;
    uart_line_pkg::byte_t b;
    uart_line_pkg::byte_t x;
    int e;
    int g;
    int n_pass;
    int n_fail;
    int err_before;
    seed = 32'he006daab;
    errors = 0;
    rdy_cnt = 0;
    err_cnt = 0;
    n_pass = 0;
    n_fail = 0;
    rst_n = 1'b0;
    cmd_in = '0;
    cmd_vld = 1'b0;
    rx = 1'b1;
    fd = $fopen("dv/uart_trace.txt", "r");
    if (fd == 0) begin
      $display("could not open trace file dv/uart_trace.txt");
      errors++;
    end else begin
      while ($fgets(line, fd) > 0) begin
        if (line.len() > 0 && line[0] != "#" &&
            $sscanf(line, "%h %h %d %d %h", c, b, e, g, x) == 5) begin
          t_cmd.push_back(c);
          t_rsp.push_back(b);
          t_err.push_back(e);
          t_gap.push_back(g);
          t_exp.push_back(x);
        end
      end
      $fclose(fd);
    end
    fork
      watch_timeout((t_cmd.size() + 1) * TEST_CYCLES);
    join_none
    repeat (10) @(negedge clk);
    rst_n = 1'b1;
    // idle line after reset
    err_before = errors;
    repeat (4 * CPB) begin
      @(negedge clk);
      if (tx !== 1'b1 || cmd_rdy !== 1'b1) report_mismatch("tx or cmd_rdy low after reset");
    end
    if (rdy_cnt != 0 || err_cnt != 0) report_mismatch("response pulse before any command");
    if (errors == err_before) begin
      $display("test 0 reset idle ok");
      n_pass++;
    end else begin
      $display("test 0 reset idle FAILED");
      n_fail++;
    end
    for (int n = 0; n < t_cmd.size(); n++) begin
      err_before = errors;
      run_test(n);
      if (errors == err_before) begin
        $display("test %0d cmd %h ok", n + 1, t_cmd[n]);
        n_pass++;
      end else begin
        $display("test %0d cmd %h FAILED", n + 1, t_cmd[n]);
        n_fail++;
      end
    end
    $display("tests passed %0d failed %0d", n_pass, n_fail);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// File: dv/uart_trace.txt
# cmd rsp err gap exp : command hex, response byte hex, error 0 none 1 parity 2 stop low,
# idle gap in bits, expected read byte hex (00 if none); a write sends rsp as stray rx traffic
8a5c 00 0 0 00
1200 a7 0 1 a7
3400 3c 1 0 00
7f00 ff 2 2 00
c1ff 96 1 0 00
0500 00 0 0 00
0600 81 0 3 81
ff01 55 0 4 00
9eaa 33 2 1 00
2b00 e4 0 0 e4

// File: all.f
common/uart_line_pkg.sv
common/uart_cmd_pkg.sv
common/tx_lane_if.sv
rtl/baud_timer.sv
uart_core/uart_tx_shift.sv
uart_core/uart_rx_shift.sv
rtl/cmd_sequencer.sv
rtl/uart_cmd_bridge.sv
dv/tb_uart_cmd_bridge.sv

// File: run.sh
#!/bin/sh
# build and run the UART command bridge testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f all.f --top-module tb_uart_cmd_bridge \
  -o sim_tb_uart_cmd_bridge > build.log 2>&1

./obj_dir/sim_tb_uart_cmd_bridge > sim.log 2>&1
cat sim.log

if grep -q "Regression passed" sim.log; then
  echo "simulation PASS"
  exit 0
else
  echo "simulation FAIL"
  exit 1
fi
